//--- Bender.yml
package:
  name: lsu_mem

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/axi_channel_slice.sv
      - hw/lsu.sv
      - hw/axi_sram.sv
      - hw/lsu_mem_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - test/lsu_mem_checker.sv
      - test/lsu_mem_tb.sv

//--- compile.f
+incdir+hw
hw/lsu_pkg.sv
hw/axi_channel_slice.sv
hw/lsu.sv
hw/axi_sram.sv
hw/lsu_mem_top.sv
test/lsu_mem_checker.sv
test/lsu_mem_tb.sv

//--- hw/axi_channel_slice.sv
module axi_channel_slice #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,

  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,

  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     skid_valid;
  payload_t skid_data;
  logic     load_out;
  logic     in_fire;

  // ready only depends on the skid flop.
  assign in_ready = ~skid_valid;
  assign in_fire  = in_valid & in_ready;

  // output register is free or drains this cycle.
  assign load_out = ~out_valid | out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_out) begin
      out_valid  <= skid_valid | in_valid;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (load_out) begin
      out_data <= skid_valid ? skid_data : in_data;
    end else if (in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

//--- hw/axi_sram.sv
`include "lsu_settings.svh"

module axi_sram import lsu_pkg::*; #(
  parameter int words = `LSU_MEM_WORDS
) (
  input  logic    clock,
  input  logic    reset,

  input  logic    ar_valid,
  output logic    ar_ready,
  input  axi_ar_t ar,
  output logic    r_valid,
  input  logic    r_ready,
  output axi_r_t  r,

  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_aw_t aw,
  input  logic    w_valid,
  output logic    w_ready,
  input  axi_w_t  w,
  output logic    b_valid,
  input  logic    b_ready,
  output axi_b_t  b
);

  localparam int idx_w = (words > 1) ? $clog2(words) : 1;
  localparam int nbytes = `LSU_XLEN / 8;

  logic [`LSU_XLEN-1:0] mem [words];

  logic                 ar_fire;
  logic [idx_w-1:0]     rd_idx;
  logic [`LSU_XLEN-1:0] r_data;
  logic [`LSU_ID_W-1:0] r_id;

  logic                 aw_fire;
  logic                 w_fire;
  logic                 b_fire;
  logic                 aw_held;
  logic                 w_held;
  logic                 do_write;
  axi_aw_t              aw_q;
  axi_w_t               w_q;
  logic [idx_w-1:0]     wr_idx;

  // ====================
  // read channel.

  assign ar_ready = ~r_valid;
  assign ar_fire  = ar_valid & ar_ready;
  assign rd_idx   = idx_w'((ar.addr >> 2) % words);

  assign r = '{id: r_id, data: r_data, resp: 2'b00, last: 1'b1};

  // ====================
  // write channel.

  assign aw_ready = ~aw_held;
  assign w_ready  = ~w_held;
  assign aw_fire  = aw_valid & aw_ready;
  assign w_fire   = w_valid & w_ready;
  assign b_fire   = b_valid & b_ready;
  assign wr_idx   = idx_w'((aw_q.addr >> 2) % words);

  // both halves captured and no response raised yet.
  assign do_write = aw_held & w_held & ~b_valid;

  assign b = '{id: aw_q.id, resp: 2'b00};

  always_ff @(posedge clock) begin
    if (reset) begin
      r_valid <= 1'b0;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (ar_fire) r_valid <= 1'b1;
      else if (r_ready) r_valid <= 1'b0;

      // held until the response goes out.
      if (aw_fire) aw_held <= 1'b1;
      else if (b_fire) aw_held <= 1'b0;
      if (w_fire) w_held <= 1'b1;
      else if (b_fire) w_held <= 1'b0;

      if (do_write) b_valid <= 1'b1;
      else if (b_ready) b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      r_data <= mem[rd_idx];
      r_id   <= ar.id;
    end
    if (aw_fire) aw_q <= aw;
    if (w_fire) w_q <= w;
    if (do_write) begin
      for (int i = 0; i < nbytes; i++) begin
        if (w_q.strb[i]) mem[wr_idx][8*i +: 8] <= w_q.data[8*i +: 8];
      end
    end
  end

endmodule

//--- hw/lsu.sv
module lsu import lsu_pkg::*; (
  input  logic        clock,
  input  logic        reset,

  input  logic        in_valid,
  output logic        in_ready,
  input  lsu_req_t    req,

  input  logic        out_ready,
  output logic        out_valid,
  output logic [31:0] out_rdata,

  output logic        ar_valid,
  input  logic        ar_ready,
  output axi_ar_t     ar,
  input  logic        r_valid,
  output logic        r_ready,
  input  axi_r_t      r,

  output logic        aw_valid,
  input  logic        aw_ready,
  output axi_aw_t     aw,
  output logic        w_valid,
  input  logic        w_ready,
  output axi_w_t      w,
  input  logic        b_valid,
  output logic        b_ready
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HOLD,
    ST_LOAD_REQ,
    ST_LOAD_RESP,
    ST_STORE_REQ,
    ST_STORE_ADDR,
    ST_STORE_DATA,
    ST_STORE_RESP
  } state_t;

  state_t      state;
  state_t      state_next;
  state_t      first_state;
  lsu_req_t    cur;
  logic [31:0] load_val;
  logic        in_fire;
  logic [4:0]  shamt;
  logic [31:0] rdata_shifted;
  logic [31:0] rdata_ext;
  logic [31:0] wdata_shifted;
  logic [3:0]  size_mask;
  logic [3:0]  wstrb;

  assign in_ready    = (state == ST_IDLE) | ((state == ST_HOLD) & out_ready);
  assign in_fire     = in_valid & in_ready;
  assign first_state = req.op.store ? ST_STORE_REQ : ST_LOAD_REQ;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (in_fire) begin
      cur <= req;
    end
    if ((state == ST_LOAD_RESP) & r_valid) begin
      load_val <= rdata_ext;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (in_valid) state_next = first_state;
      end
      // back-to-back request skips idle.
      ST_HOLD: begin
        if (out_ready) state_next = in_valid ? first_state : ST_IDLE;
      end
      ST_LOAD_REQ: begin
        if (ar_ready) state_next = ST_LOAD_RESP;
      end
      ST_LOAD_RESP: begin
        if (r_valid) state_next = ST_HOLD;
      end
      ST_STORE_REQ: begin
        if (aw_ready & w_ready) state_next = ST_STORE_RESP;
        else if (aw_ready) state_next = ST_STORE_DATA;
        else if (w_ready) state_next = ST_STORE_ADDR;
      end
      ST_STORE_ADDR: begin
        if (aw_ready) state_next = ST_STORE_RESP;
      end
      ST_STORE_DATA: begin
        if (w_ready) state_next = ST_STORE_RESP;
      end
      ST_STORE_RESP: begin
        if (b_valid) state_next = ST_HOLD;
      end
      default: state_next = ST_IDLE;
    endcase
  end

  assign out_valid = state == ST_HOLD;
  assign out_rdata = load_val;

  // byte offset in bits.
  assign shamt = {cur.addr[1:0], 3'b000};

  // ====================
  // load path.

  assign ar_valid = state == ST_LOAD_REQ;
  assign ar       = '{id: '0, addr: cur.addr, len: 8'd0, size: {1'b0, cur.op.size},
                      burst: 2'b00};
  assign r_ready  = state == ST_LOAD_RESP;

  assign rdata_shifted = r.data >> shamt;

  always_comb begin
    case (cur.op.size)
      2'd0:    rdata_ext = {{24{rdata_shifted[7] & cur.op.is_signed}}, rdata_shifted[7:0]};
      2'd1:    rdata_ext = {{16{rdata_shifted[15] & cur.op.is_signed}}, rdata_shifted[15:0]};
      default: rdata_ext = rdata_shifted;
    endcase
  end

  // ====================
  // store path.

  always_comb begin
    case (cur.op.size)
      2'd0:    size_mask = 4'b0001;
      2'd1:    size_mask = 4'b0011;
      2'd2:    size_mask = 4'b1111;
      default: size_mask = 4'b0000;
    endcase
  end

  // bytes past the word boundary fall off here.
  assign wdata_shifted = cur.wdata << shamt;
  assign wstrb         = size_mask << cur.addr[1:0];

  assign aw_valid = (state == ST_STORE_REQ) | (state == ST_STORE_ADDR);
  assign aw       = '{id: '0, addr: cur.addr, len: 8'd0, size: {1'b0, cur.op.size},
                      burst: 2'b00};
  assign w_valid  = (state == ST_STORE_REQ) | (state == ST_STORE_DATA);
  assign w        = '{data: wdata_shifted, strb: wstrb, last: 1'b1};
  assign b_ready  = state == ST_STORE_RESP;

endmodule

//--- hw/lsu_mem_top.sv
module lsu_mem_top import lsu_pkg::*; (
  input  logic        clock,
  input  logic        reset,

  input  logic        in_valid,
  output logic        in_ready,
  input  lsu_req_t    req,

  output logic        out_valid,
  input  logic        out_ready,
  output logic [31:0] out_rdata
);

  // lsu side and memory side of each channel.
  logic    lsu_ar_valid, lsu_ar_ready, mem_ar_valid, mem_ar_ready;
  axi_ar_t lsu_ar, mem_ar;
  logic    lsu_aw_valid, lsu_aw_ready, mem_aw_valid, mem_aw_ready;
  axi_aw_t lsu_aw, mem_aw;
  logic    lsu_w_valid, lsu_w_ready, mem_w_valid, mem_w_ready;
  axi_w_t  lsu_w, mem_w;
  logic    lsu_r_valid, lsu_r_ready, mem_r_valid, mem_r_ready;
  axi_r_t  lsu_r, mem_r;
  logic    lsu_b_valid, lsu_b_ready, mem_b_valid, mem_b_ready;
  axi_b_t  mem_b;

  lsu lsu_inst (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .req       (req),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_rdata (out_rdata),
    .ar_valid  (lsu_ar_valid),
    .ar_ready  (lsu_ar_ready),
    .ar        (lsu_ar),
    .r_valid   (lsu_r_valid),
    .r_ready   (lsu_r_ready),
    .r         (lsu_r),
    .aw_valid  (lsu_aw_valid),
    .aw_ready  (lsu_aw_ready),
    .aw        (lsu_aw),
    .w_valid   (lsu_w_valid),
    .w_ready   (lsu_w_ready),
    .w         (lsu_w),
    .b_valid   (lsu_b_valid),
    .b_ready   (lsu_b_ready)
  );

  // ====================
  // request channels from lsu to memory.

  axi_channel_slice #(.payload_t(axi_ar_t)) ar_slice (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (lsu_ar_valid),
    .in_ready  (lsu_ar_ready),
    .in_data   (lsu_ar),
    .out_valid (mem_ar_valid),
    .out_ready (mem_ar_ready),
    .out_data  (mem_ar)
  );

  axi_channel_slice #(.payload_t(axi_aw_t)) aw_slice (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (lsu_aw_valid),
    .in_ready  (lsu_aw_ready),
    .in_data   (lsu_aw),
    .out_valid (mem_aw_valid),
    .out_ready (mem_aw_ready),
    .out_data  (mem_aw)
  );

  axi_channel_slice #(.payload_t(axi_w_t)) w_slice (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (lsu_w_valid),
    .in_ready  (lsu_w_ready),
    .in_data   (lsu_w),
    .out_valid (mem_w_valid),
    .out_ready (mem_w_ready),
    .out_data  (mem_w)
  );

  // ====================
  // response channels from memory to lsu.

  axi_channel_slice #(.payload_t(axi_r_t)) r_slice (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (mem_r_valid),
    .in_ready  (mem_r_ready),
    .in_data   (mem_r),
    .out_valid (lsu_r_valid),
    .out_ready (lsu_r_ready),
    .out_data  (lsu_r)
  );

  // the unit takes no B payload.
  axi_channel_slice #(.payload_t(axi_b_t)) b_slice (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (mem_b_valid),
    .in_ready  (mem_b_ready),
    .in_data   (mem_b),
    .out_valid (lsu_b_valid),
    .out_ready (lsu_b_ready),
    .out_data  ()
  );

  axi_sram sram_inst (
    .clock    (clock),
    .reset    (reset),
    .ar_valid (mem_ar_valid),
    .ar_ready (mem_ar_ready),
    .ar       (mem_ar),
    .r_valid  (mem_r_valid),
    .r_ready  (mem_r_ready),
    .r        (mem_r),
    .aw_valid (mem_aw_valid),
    .aw_ready (mem_aw_ready),
    .aw       (mem_aw),
    .w_valid  (mem_w_valid),
    .w_ready  (mem_w_ready),
    .w        (mem_w),
    .b_valid  (mem_b_valid),
    .b_ready  (mem_b_ready),
    .b        (mem_b)
  );

endmodule

//--- hw/lsu_pkg.sv
`include "lsu_settings.svh"

package lsu_pkg;

  // same bit order as the core's 4-bit ls code.
  typedef struct packed {
    logic       store;
    logic       is_signed;
    logic [1:0] size;
  } ls_op_t;

  typedef struct packed {
    ls_op_t                 op;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_XLEN-1:0]   wdata;
  } lsu_req_t;

  // ====================
  // AXI channel payloads.

  typedef struct packed {
    logic [`LSU_ID_W-1:0]   id;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } axi_ar_t;

  // write address has the same fields.
  typedef axi_ar_t axi_aw_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0]   data;
    logic [`LSU_XLEN/8-1:0] strb;
    logic                   last;
  } axi_w_t;

  typedef struct packed {
    logic [`LSU_ID_W-1:0] id;
    logic [`LSU_XLEN-1:0] data;
    logic [1:0]           resp;
    logic                 last;
  } axi_r_t;

  typedef struct packed {
    logic [`LSU_ID_W-1:0] id;
    logic [1:0]           resp;
  } axi_b_t;

endpackage

//--- hw/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ====================
// datapath widths.

// register and bus data width.
`define LSU_XLEN 32

// byte address width on the AXI side.
`define LSU_ADDR_W 32

// ====================
// memory and bus.

// default depth of the test memory, in words.
`define LSU_MEM_WORDS 256

// AXI transaction id width.
`define LSU_ID_W 4

`endif

//--- test/lsu_mem_checker.sv
module lsu_mem_checker import lsu_pkg::*; (
  input logic        clock,
  input logic        reset,
  input logic        ar_valid,
  input logic        ar_ready,
  input logic        aw_valid,
  input logic        aw_ready,
  input logic        w_valid,
  input logic        w_ready,
  input logic        out_valid,
  input logic        out_ready,
  input logic [31:0] out_rdata
);

  int fails = 0;

  // ====================
  // AXI request channels.

  ar_held: assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid)
    else begin
      $error("ar_valid dropped before ar_ready");
      fails++;
    end

  aw_held: assert property (@(posedge clock) disable iff (reset)
    aw_valid && !aw_ready |=> aw_valid)
    else begin
      $error("aw_valid dropped before aw_ready");
      fails++;
    end

  w_held: assert property (@(posedge clock) disable iff (reset)
    w_valid && !w_ready |=> w_valid)
    else begin
      $error("w_valid dropped before w_ready");
      fails++;
    end

  // ====================
  // result side.

  out_held: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_rdata))
    else begin
      $error("result changed or dropped while out_ready was low");
      fails++;
    end

  reset_clears: assert property (@(posedge clock) reset |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      fails++;
    end

endmodule

bind lsu lsu_mem_checker checker_inst (.*);

//--- test/lsu_mem_tb.sv
`include "lsu_settings.svh"

module lsu_mem_tb import lsu_pkg::*; ();

  // operations per test in run order.
  localparam int num_ops = 32 + 17 + 34 + 4 + 64;
  localparam int watchdog_cycles = num_ops * 40 + 4;

  logic        clock;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  lsu_req_t    req;
  logic        out_valid;
  logic        out_ready;
  logic [31:0] out_rdata;

  int errors = 0;
  int proto_fails;

  // byte-wide copy of the memory contents.
  logic [7:0] ref_mem [4*`LSU_MEM_WORDS];

  lsu_mem_top lsu_mem_top_inst (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .req       (req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rdata (out_rdata)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

  // ====================
  // reference model.

  task automatic update_ref(input logic [31:0] addr, input logic [1:0] size,
                            input logic [31:0] data);
    int base;
    int off;
    base = ((addr >> 2) % `LSU_MEM_WORDS) * 4;
    off  = addr[1:0];
    // bytes past the word end are dropped.
    for (int i = 0; i < (1 << size); i++) begin
      if (off + i < 4) ref_mem[base + off + i] = data[8*i +: 8];
    end
  endtask

  function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                input logic [1:0] size, input logic sgn);
    logic [31:0] val;
    int base;
    int off;
    int n;
    val  = '0;
    base = ((addr >> 2) % `LSU_MEM_WORDS) * 4;
    off  = addr[1:0];
    n    = 1 << size;
    for (int i = 0; i < n; i++) begin
      if (off + i < 4) val[8*i +: 8] = ref_mem[base + off + i];
    end
    if (sgn && n < 4 && val[8*n-1]) val = val | (32'hffff_ffff << (8*n));
    return val;
  endfunction

  // ====================
  // request and response.

  task automatic send_req(input ls_op_t op, input logic [31:0] addr, input logic [31:0] wdata);
    in_valid = 1'b1;
    req      = '{op: op, addr: addr, wdata: wdata};
    do @(posedge clock); while (!in_ready);
    #10;
    in_valid = 1'b0;
  endtask

  task automatic wait_result(output logic [31:0] data);
    do @(posedge clock); while (!out_valid);
    data = out_rdata;
    #10;
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [1:0] size,
                          input logic [31:0] wdata);
    ls_op_t      op;
    logic [31:0] unused;
    op = '{store: 1'b1, is_signed: 1'b0, size: size};
    send_req(op, addr, wdata);
    wait_result(unused);
    update_ref(addr, size, wdata);
  endtask

  task automatic do_load(input logic [31:0] addr, input logic [1:0] size, input logic sgn);
    ls_op_t      op;
    logic [31:0] got;
    logic [31:0] exp;
    op  = '{store: 1'b0, is_signed: sgn, size: size};
    exp = expected_load(addr, size, sgn);
    send_req(op, addr, 32'h0);
    wait_result(got);
    assert (got === exp) else begin
      $display("CHECK FAILED out_rdata at addr %h: expected %h, got %h", addr, exp, got);
      errors++;
    end
  endtask

  // ====================
  // directed tests.

  task automatic word_round_trip();
    for (int i = 0; i < 16; i++) do_store(32'h100 + 4*i, 2'd2, $urandom);
    for (int i = 0; i < 16; i++) do_load(32'h100 + 4*i, 2'd2, 1'b0);
  endtask

  task automatic partial_stores();
    do_store(32'h200, 2'd2, $urandom);
    for (int sz = 0; sz < 2; sz++) begin
      for (int off = 0; off < 4; off++) begin
        do_store(32'h200 + off, 2'(sz), $urandom);
        do_load(32'h200, 2'd2, 1'b0);
      end
    end
  endtask

  task automatic load_extension();
    // top bits set in every byte of the first word and clear in the second.
    do_store(32'h300, 2'd2, 32'h8f9a_b7c5);
    do_store(32'h304, 2'd2, 32'h1f3a_475c);
    for (int w = 0; w < 2; w++) begin
      for (int off = 0; off < 4; off++) begin
        for (int sz = 0; sz < 2; sz++) begin
          do_load(32'h300 + 4*w + off, 2'(sz), 1'b0);
          do_load(32'h300 + 4*w + off, 2'(sz), 1'b1);
        end
      end
    end
  endtask

  task automatic output_backpressure();
    ls_op_t      op;
    logic [31:0] addr;
    logic [31:0] held;
    logic [31:0] exp;
    int          hold_cycles;
    op = '{store: 1'b0, is_signed: 1'b1, size: 2'd1};
    for (int k = 0; k < 4; k++) begin
      addr        = 32'h100 + 5*k;
      exp         = expected_load(addr, op.size, op.is_signed);
      hold_cycles = $urandom_range(1, 8);
      out_ready   = 1'b0;
      send_req(op, addr, 32'h0);
      do @(posedge clock); while (!out_valid);
      held = out_rdata;
      repeat (hold_cycles) begin
        @(posedge clock);
        assert (out_valid && !in_ready) else begin
          $display("back-pressure: out_valid dropped or in_ready rose while stalled");
          errors++;
        end
        assert (out_rdata === held) else begin
          $display("CHECK FAILED out_rdata while stalled: expected %h, got %h", held, out_rdata);
          errors++;
        end
      end
      #10;
      out_ready = 1'b1;
      @(posedge clock);
      assert (out_rdata === exp) else begin
        $display("CHECK FAILED out_rdata on release: expected %h, got %h", exp, out_rdata);
        errors++;
      end
      #10;
    end
  endtask

  task automatic back_to_back();
    lsu_req_t    seq [64];
    int          sent;
    int          done;
    int          extra;
    logic        accepted;
    logic        finished;
    logic [31:0] exp;
    for (int i = 0; i < 64; i++) begin
      seq[i].op.store     = 1'($urandom_range(0, 1));
      seq[i].op.is_signed = 1'($urandom_range(0, 1));
      seq[i].op.size      = 2'($urandom_range(0, 2));
      seq[i].addr         = 32'h100 + $urandom_range(0, 63);
      seq[i].wdata        = $urandom;
    end
    sent      = 0;
    done      = 0;
    out_ready = 1'b1;
    in_valid  = 1'b1;
    req       = seq[0];
    while (done < 64) begin
      @(posedge clock);
      accepted = in_valid & in_ready;
      finished = out_valid & out_ready;
      if (finished) begin
        if (seq[done].op.store) begin
          update_ref(seq[done].addr, seq[done].op.size, seq[done].wdata);
        end else begin
          exp = expected_load(seq[done].addr, seq[done].op.size, seq[done].op.is_signed);
          assert (out_rdata === exp) else begin
            $display("CHECK FAILED out_rdata at addr %h: expected %h, got %h",
                     seq[done].addr, exp, out_rdata);
            errors++;
          end
        end
        done++;
      end
      #10;
      if (accepted) begin
        sent++;
        if (sent < 64) req = seq[sent];
        else in_valid = 1'b0;
      end
    end
    in_valid = 1'b0;
    extra    = 0;
    repeat (4) begin
      @(posedge clock);
      if (out_valid) extra++;
    end
    #10;
    assert (sent == 64 && extra == 0) else begin
      $display("back-to-back: %0d requests accepted, %0d results, %0d extra results",
               sent, done, extra);
      errors++;
    end
  endtask

  // ====================
  // main sequence.

  initial begin
    void'($urandom(32'h23c7_e2fe));
    reset     = 1'b1;
    in_valid  = 1'b0;
    req       = '0;
    out_ready = 1'b1;
    repeat (4) @(posedge clock);
    #10;
    reset = 1'b0;

    word_round_trip();
    partial_stores();
    load_extension();
    output_backpressure();
    back_to_back();

    repeat (2) @(posedge clock);
    proto_fails = lsu_mem_top_inst.lsu_inst.checker_inst.fails;
    $display("errors: %0d value checks, %0d protocol assertions", errors, proto_fails);
    if (errors == 0 && proto_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
